//--- axi_read_engine/axi_read_engine.sv
/* One read burst at a time, one SRAM read per beat. Best case 3 cycles from
   AR acceptance to RVALID and 3 cycles between beats; R stalls hold the beat */
`timescale 1ns/10ps

module axi_read_engine
(
  input  logic                           ACLK,
  input  logic                           ARESETn,
  input  axi_mem_pkg::axi_addr_t         ar_i,
  input  logic                           ar_valid_i,
  output logic                           ar_ready_o,
  output axi_mem_pkg::axi_r_t            r_o,
  output logic                           r_valid_o,
  input  logic                           r_ready_i,
  output logic                           rd_req_o,
  output axi_mem_pkg::mem_req_t          rd_mem_o,
  input  logic                           rd_gnt_i,
  input  logic [axi_mem_pkg::DATA_W-1:0] mem_q_i
);

  axi_mem_pkg::rd_state_e             state_q;
  axi_mem_pkg::rd_state_e             state_d;
  logic [axi_mem_pkg::MEM_ADDR_W-1:0] addr_q;   // Word address of next read
  logic [axi_mem_pkg::LEN_W-1:0]      cnt_q;    // Beats left after current
  logic                               ready_q;
  logic                               valid_q;
  axi_mem_pkg::axi_r_t                r_q;      // R output register
  logic                               ar_fire;
  logic                               r_fire;

  assign ar_fire = ar_valid_i & ready_q;
  assign r_fire  = valid_q & r_ready_i;

  // ----------------------------------------------------------
  // Beat sequencing
  // ----------------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      axi_mem_pkg::RD_IDLE:
        if (ar_fire)
          state_d = axi_mem_pkg::RD_ISSUE;
      axi_mem_pkg::RD_ISSUE:
        if (rd_gnt_i)
          state_d = axi_mem_pkg::RD_WAIT;
      axi_mem_pkg::RD_WAIT:
        state_d = axi_mem_pkg::RD_HOLD;   // Q valid this cycle
      axi_mem_pkg::RD_HOLD:
        if (r_fire)
        begin
          if (cnt_q == '0)
            state_d = axi_mem_pkg::RD_IDLE;
          else
            state_d = axi_mem_pkg::RD_ISSUE;
        end
      default:
        state_d = axi_mem_pkg::RD_IDLE;
    endcase
  end

  always_ff @(posedge ACLK, negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      state_q <= axi_mem_pkg::RD_IDLE;
      ready_q <= 1'b0;
      valid_q <= 1'b0;
      cnt_q   <= '0;
      addr_q  <= '0;
    end
    else
    begin
      state_q <= state_d;
      ready_q <= (state_d == axi_mem_pkg::RD_IDLE);
      valid_q <= (state_d == axi_mem_pkg::RD_HOLD);

      if (ar_fire)
        cnt_q <= ar_i.len;
      else if (r_fire && cnt_q != '0)
        cnt_q <= cnt_q - 1'b1;

      // Wraps inside the word space
      if (ar_fire)
        addr_q <= ar_i.addr[axi_mem_pkg::MEM_ADDR_W+axi_mem_pkg::OFFSET_BITS-1:
                            axi_mem_pkg::OFFSET_BITS];
      else if (rd_req_o && rd_gnt_i)
        addr_q <= addr_q + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // R output register
  // ----------------------------------------------------------
  always_ff @(posedge ACLK)
  begin
    if (ar_fire)
      r_q.id <= ar_i.id;
    if (state_q == axi_mem_pkg::RD_WAIT)
    begin
      r_q.data <= mem_q_i;
      r_q.last <= (cnt_q == '0);
    end
  end

  assign ar_ready_o = ready_q;
  assign r_o        = r_q;
  assign r_valid_o  = valid_q;

  // Memory request
  assign rd_req_o       = (state_q == axi_mem_pkg::RD_ISSUE);
  assign rd_mem_o.op    = axi_mem_pkg::MEM_READ;
  assign rd_mem_o.addr  = addr_q;
  assign rd_mem_o.wdata = '0;
  assign rd_mem_o.be    = '0;

endmodule

//--- axi_write_engine/axi_write_engine.sv
/* One write burst at a time. WLAST is ignored and the AW length decides the
   end of the burst; each W beat is written in the cycle it is accepted */
`timescale 1ns/10ps

module axi_write_engine
(
  input  logic                         ACLK,
  input  logic                         ARESETn,
  input  axi_mem_pkg::axi_addr_t       aw_i,
  input  logic                         aw_valid_i,
  output logic                         aw_ready_o,
  input  axi_mem_pkg::axi_w_t          w_i,
  input  logic                         w_valid_i,
  output logic                         w_ready_o,
  output logic [axi_mem_pkg::ID_W-1:0] b_id_o,
  output logic                         b_valid_o,
  input  logic                         b_ready_i,
  output logic                         wr_req_o,
  output axi_mem_pkg::mem_req_t        wr_mem_o,
  input  logic                         wr_gnt_i
);

  axi_mem_pkg::wr_state_e             state_q;
  axi_mem_pkg::wr_state_e             state_d;
  logic [axi_mem_pkg::ID_W-1:0]       id_q;
  logic [axi_mem_pkg::MEM_ADDR_W-1:0] addr_q;
  logic [axi_mem_pkg::LEN_W-1:0]      cnt_q;    // Beats left after current
  logic                               ready_q;
  logic                               aw_fire;
  logic                               w_fire;

  assign aw_fire = aw_valid_i & ready_q;
  assign w_fire  = wr_req_o & wr_gnt_i;

  // ----------------------------------------------------------
  // Burst control
  // ----------------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      axi_mem_pkg::WR_IDLE:
        if (aw_fire)
          state_d = axi_mem_pkg::WR_DATA;
      axi_mem_pkg::WR_DATA:
        if (w_fire && cnt_q == '0)
          state_d = axi_mem_pkg::WR_RESP;  // Counted last beat written
      axi_mem_pkg::WR_RESP:
        if (b_ready_i)
          state_d = axi_mem_pkg::WR_IDLE;
      default:
        state_d = axi_mem_pkg::WR_IDLE;
    endcase
  end

  always_ff @(posedge ACLK, negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      state_q <= axi_mem_pkg::WR_IDLE;
      ready_q <= 1'b0;
      cnt_q   <= '0;
      addr_q  <= '0;
    end
    else
    begin
      state_q <= state_d;
      ready_q <= (state_d == axi_mem_pkg::WR_IDLE);

      if (aw_fire)
        cnt_q <= aw_i.len;
      else if (w_fire && cnt_q != '0)
        cnt_q <= cnt_q - 1'b1;

      if (aw_fire)
        addr_q <= aw_i.addr[axi_mem_pkg::MEM_ADDR_W+axi_mem_pkg::OFFSET_BITS-1:
                            axi_mem_pkg::OFFSET_BITS];
      else if (w_fire)
        addr_q <= addr_q + 1'b1;             // Natural wrap at the top
    end
  end

  // Held for the whole burst and its response
  always_ff @(posedge ACLK)
  begin
    if (aw_fire)
      id_q <= aw_i.id;
  end

  // ----------------------------------------------------------
  // Channel outputs and memory request
  // ----------------------------------------------------------
  assign aw_ready_o = ready_q;

  // W beat accepted only when the SRAM takes it
  assign w_ready_o = wr_gnt_i;

  assign b_id_o    = id_q;
  assign b_valid_o = (state_q == axi_mem_pkg::WR_RESP);

  assign wr_req_o       = (state_q == axi_mem_pkg::WR_DATA) & w_valid_i;
  assign wr_mem_o.op    = axi_mem_pkg::MEM_WRITE;
  assign wr_mem_o.addr  = addr_q;
  assign wr_mem_o.wdata = w_i.data;
  assign wr_mem_o.be    = w_i.strb;

endmodule

//--- common/axi_mem_pkg.sv
/* Every burst is treated as full-width INCR and every response is implicitly OKAY.
   The SRAM word address is taken from byte address bits [MEM_ADDR_W+2:3] */
package axi_mem_pkg;

  // ----------------------------------------------------------
  // Bus and memory sizes
  // ----------------------------------------------------------
  localparam int ADDR_W      = 32;  // AXI byte address
  localparam int DATA_W      = 64;
  localparam int STRB_W      = DATA_W / 8;
  localparam int ID_W        = 16;
  localparam int LEN_W       = 8;   // Up to 256 beats
  localparam int MEM_ADDR_W  = 13;  // SRAM word address
  localparam int OFFSET_BITS = 3;   // Byte offset inside one word

  // ----------------------------------------------------------
  // AXI channel beats
  // ----------------------------------------------------------
  // One AW or AR beat
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } axi_addr_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic              last;
  } axi_r_t;

  // ----------------------------------------------------------
  // Memory port and engine states
  // ----------------------------------------------------------
  typedef enum logic {MEM_READ = 1'b0, MEM_WRITE = 1'b1} mem_op_e;

  // One access asked for by an engine
  typedef struct packed {
    mem_op_e               op;
    logic [MEM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
    logic [STRB_W-1:0]     be;
  } mem_req_t;

  typedef enum logic [1:0] {RD_IDLE, RD_ISSUE, RD_WAIT, RD_HOLD} rd_state_e;

  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;

endpackage

//--- list.f
common/axi_mem_pkg.sv
axi_read_engine/axi_read_engine.sv
axi_write_engine/axi_write_engine.sv
verilog/mem_port_arbiter.sv
verilog/axi_mem_bridge.sv
verification/sram_model.sv
verification/axi_mem_bridge_checker.sv
verification/tb_axi_mem_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI memory bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module tb_axi_mem_bridge -o sim_tb

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- verification/axi_mem_bridge_checker.sv
/* Bound into every axi_mem_bridge and reads its internal grant nets rd_gnt
   and wr_gnt. fail_cnt holds the number of failed assertions */
`timescale 1ns/10ps

module axi_mem_bridge_checker
(
  input  logic                         ACLK,
  input  logic                         ARESETn,
  input  axi_mem_pkg::axi_r_t          r_i,
  input  logic                         r_valid_i,
  input  logic                         r_ready_i,
  input  logic [axi_mem_pkg::ID_W-1:0] b_id_i,
  input  logic                         b_valid_i,
  input  logic                         b_ready_i,
  input  logic                         mem_cen_i,
  input  logic                         mem_wen_i,
  input  logic                         rd_gnt_i,
  input  logic                         wr_gnt_i
);

  int fail_cnt = 0;

  // ----------------------------------------------------------
  // Response channels hold until taken
  // ----------------------------------------------------------
  r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
  else
  begin
    $error("R beat dropped or changed while RREADY was low");
    fail_cnt++;
  end

  b_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_id_i))
  else
  begin
    $error("B response dropped or changed while BREADY was low");
    fail_cnt++;
  end

  // ----------------------------------------------------------
  // Memory port
  // ----------------------------------------------------------
  wen_needs_cen: assert property (@(posedge ACLK) disable iff (!ARESETn)
    !mem_wen_i |-> !mem_cen_i)
  else
  begin
    $error("SRAM write enable low without chip enable");
    fail_cnt++;
  end

  one_grant: assert property (@(posedge ACLK) disable iff (!ARESETn)
    !(rd_gnt_i && wr_gnt_i))
  else
  begin
    $error("Read and write engines granted in the same cycle");
    fail_cnt++;
  end

endmodule

bind axi_mem_bridge axi_mem_bridge_checker u_checker
(
  .ACLK      ( ACLK      ),
  .ARESETn   ( ARESETn   ),
  .r_i       ( r_o       ),
  .r_valid_i ( r_valid_o ),
  .r_ready_i ( r_ready_i ),
  .b_id_i    ( b_id_o    ),
  .b_valid_i ( b_valid_o ),
  .b_ready_i ( b_ready_i ),
  .mem_cen_i ( mem_cen_o ),
  .mem_wen_i ( mem_wen_o ),
  .rd_gnt_i  ( rd_gnt    ),
  .wr_gnt_i  ( wr_gnt    )
);

//--- verification/sram_model.sv
/* Byte-enabled single-port SRAM, Q valid the cycle after a read with CEN low.
   Starts filled with a pattern built from the whole word address */
`timescale 1ns/10ps

module sram_model
(
  input  logic                               ACLK,
  input  logic                               cen_i,
  input  logic                               wen_i,
  input  logic [axi_mem_pkg::MEM_ADDR_W-1:0] addr_i,
  input  logic [axi_mem_pkg::DATA_W-1:0]     d_i,
  input  logic [axi_mem_pkg::STRB_W-1:0]     be_i,
  output logic [axi_mem_pkg::DATA_W-1:0]     q_o
);

  logic [axi_mem_pkg::DATA_W-1:0] mem [0:(1<<axi_mem_pkg::MEM_ADDR_W)-1];

  initial
  begin
    for (int a = 0; a < (1 << axi_mem_pkg::MEM_ADDR_W); a++)
      mem[a] = {4{3'b101, a[12:0]}};   // Power-up pattern
    q_o = '0;
  end

  always @(posedge ACLK)
  begin
    if (!cen_i && !wen_i)
    begin
      for (int b = 0; b < axi_mem_pkg::STRB_W; b++)
        if (be_i[b])
          mem[addr_i][8*b +: 8] <= d_i[8*b +: 8];
    end
    else if (!cen_i)
      q_o <= mem[addr_i];
  end

endmodule

//--- verification/tb_axi_mem_bridge.sv
/* Directed tests for the AXI memory bridge. Expected read data comes from a
   byte array that starts with the SRAM model's power-up pattern */
`timescale 1ns/10ps

module tb_axi_mem_bridge;

  localparam int CLK_PERIOD      = 4;
  localparam int WORDS           = 1 << axi_mem_pkg::MEM_ADDR_W;
  // Beats of all tests, each read and write counted
  localparam int TEST_BEATS      = 2*1 + 2*8 + 4 + 2 + 2*16 + 3*16;
  localparam int CYCLES_PER_BEAT = 8;
  localparam int MARGIN          = 4;
  localparam int WATCHDOG_NS     = TEST_BEATS * CYCLES_PER_BEAT * MARGIN * CLK_PERIOD;

  logic                               ACLK = 1'b0;
  logic                               ARESETn;
  axi_mem_pkg::axi_addr_t             aw_beat;
  logic                               aw_valid;
  logic                               aw_ready;
  axi_mem_pkg::axi_w_t                w_beat;
  logic                               w_valid;
  logic                               w_ready;
  logic [axi_mem_pkg::ID_W-1:0]       b_id;
  logic                               b_valid;
  logic                               b_ready;
  axi_mem_pkg::axi_addr_t             ar_beat;
  logic                               ar_valid;
  logic                               ar_ready;
  axi_mem_pkg::axi_r_t                r_beat;
  logic                               r_valid;
  logic                               r_ready;
  logic                               mem_cen;
  logic                               mem_wen;
  logic [axi_mem_pkg::MEM_ADDR_W-1:0] mem_addr;
  logic [axi_mem_pkg::DATA_W-1:0]     mem_d;
  logic [axi_mem_pkg::STRB_W-1:0]     mem_be;
  logic [axi_mem_pkg::DATA_W-1:0]     mem_q;

  logic [7:0] ref_mem [0:WORDS*8-1];  // Byte image of the SRAM
  bit         stall_en;
  int         checks;
  int         errors;

  always #(CLK_PERIOD/2) ACLK = ~ACLK;

  axi_mem_bridge uut
  (
    .ACLK (ACLK), .ARESETn (ARESETn),
    .aw_i (aw_beat), .aw_valid_i (aw_valid), .aw_ready_o (aw_ready),
    .w_i (w_beat), .w_valid_i (w_valid), .w_ready_o (w_ready),
    .b_id_o (b_id), .b_valid_o (b_valid), .b_ready_i (b_ready),
    .ar_i (ar_beat), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
    .r_o (r_beat), .r_valid_o (r_valid), .r_ready_i (r_ready),
    .mem_cen_o (mem_cen), .mem_wen_o (mem_wen), .mem_addr_o (mem_addr),
    .mem_d_o (mem_d), .mem_be_o (mem_be), .mem_q_i (mem_q)
  );

  sram_model u_sram
  (
    .ACLK (ACLK), .cen_i (mem_cen), .wen_i (mem_wen), .addr_i (mem_addr),
    .d_i (mem_d), .be_i (mem_be), .q_o (mem_q)
  );

  // ----------------------------------------------------------
  // Reference model and checking
  // ----------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic ref_write(input int word, input logic [63:0] data, input logic [7:0] strb);
    for (int b = 0; b < 8; b++)
      if (strb[b])
        ref_mem[word*8 + b] = data[8*b +: 8];
  endtask

  function automatic logic [63:0] ref_word(input int word);
    logic [63:0] val;
    for (int b = 0; b < 8; b++)
      val[8*b +: 8] = ref_mem[word*8 + b];
    return val;
  endfunction

  function automatic logic random_ready();
    logic [31:0] rnd;
    if (!stall_en)
      return 1'b1;
    rnd = $urandom;
    return (rnd[1:0] != 2'b00);  // Low one cycle in four
  endfunction

  // ----------------------------------------------------------
  // AXI drivers, called just after a rising edge
  // ----------------------------------------------------------
  task automatic write_burst(input logic [15:0] id, input logic [31:0] addr,
                             input int len, input bit rand_strb);
    logic [63:0] data;
    logic [31:0] rnd;
    int          word;
    int          gap;
    aw_beat  <= '{id: id, addr: addr, len: len[7:0]};
    aw_valid <= 1'b1;
    do @(posedge ACLK); while (!aw_ready);
    aw_valid <= 1'b0;
    for (int beat = 0; beat <= len; beat++)
    begin
      data = {$urandom, $urandom};
      rnd  = rand_strb ? $urandom : 32'hFF;
      word = ((addr >> 3) + beat) % WORDS;  // Word index wraps at the top
      gap  = stall_en ? ($urandom % 3) : 0;
      if (gap > 0)
      begin
        w_valid <= 1'b0;
        repeat (gap) @(posedge ACLK);
      end
      w_beat  <= '{data: data, strb: rnd[7:0], last: (beat == len)};
      w_valid <= 1'b1;
      do @(posedge ACLK); while (!w_ready);
      ref_write(word, data, rnd[7:0]);
    end
    w_valid <= 1'b0;
    do
    begin
      b_ready <= random_ready();
      @(posedge ACLK);
    end
    while (!(b_valid && b_ready));
    check_value("b_id_o", b_id, id);
    b_ready <= 1'b0;
  endtask

  task automatic read_burst(input logic [15:0] id, input logic [31:0] addr, input int len);
    int beat;
    int word;
    ar_beat  <= '{id: id, addr: addr, len: len[7:0]};
    ar_valid <= 1'b1;
    do @(posedge ACLK); while (!ar_ready);
    ar_valid <= 1'b0;
    beat = 0;
    while (beat <= len)
    begin
      r_ready <= random_ready();
      @(posedge ACLK);
      if (r_valid && r_ready)
      begin
        word = ((addr >> 3) + beat) % WORDS;
        check_value("r_o.data", r_beat.data, ref_word(word));
        check_value("r_o.id", r_beat.id, id);
        check_value("r_o.last", r_beat.last, beat == len);
        beat++;
      end
    end
    r_ready <= 1'b0;
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic test_single();
    write_burst(16'h1234, 32'h0000_0100, 0, 1'b0);
    read_burst(16'h4321, 32'h0000_0100, 0);
  endtask

  task automatic test_strobed_burst();
    write_burst(16'h00B2, 32'h0000_0200, 7, 1'b1);
    read_burst(16'h00B3, 32'h0000_0200, 7);
  endtask

  // Words 8190, 8191, 0 and 1
  task automatic test_addr_wrap();
    write_burst(16'h0C01, 32'h0000_FFF0, 3, 1'b0);
    read_burst(16'h0C02, 32'h0000_0000, 0);
    read_burst(16'h0C03, 32'h0000_0008, 0);
  endtask

  task automatic test_back_pressure();
    stall_en = 1'b1;
    write_burst(16'hBEEF, 32'h0000_1000, 15, 1'b1);
    read_burst(16'hCAFE, 32'h0000_1000, 15);
    stall_en = 1'b0;
  endtask

  task automatic test_concurrent();
    fork
      write_burst(16'h0051, 32'h0000_4000, 15, 1'b1);
      read_burst(16'h0052, 32'h0000_8000, 15);
    join
    read_burst(16'h0053, 32'h0000_4000, 15);  // Written region back
  endtask

  initial
  begin
    ARESETn  = 1'b0;
    aw_beat  = '0;
    aw_valid = 1'b0;
    w_beat   = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar_beat  = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    stall_en = 1'b0;
    checks   = 0;
    errors   = 0;
    void'($urandom(32'h9cc6_59d2));
    for (int a = 0; a < WORDS; a++)
      ref_write(a, {4{3'b101, a[12:0]}}, 8'hFF);  // SRAM power-up pattern

    repeat (4) @(posedge ACLK);
    check_value("aw_ready_o", aw_ready, 1'b0);
    check_value("ar_ready_o", ar_ready, 1'b0);
    check_value("r_valid_o", r_valid, 1'b0);
    check_value("b_valid_o", b_valid, 1'b0);
    check_value("mem_cen_o", mem_cen, 1'b1);
    check_value("mem_wen_o", mem_wen, 1'b1);
    ARESETn <= 1'b1;
    @(posedge ACLK);

    test_single();
    test_strobed_burst();
    test_addr_wrap();
    test_back_pressure();
    test_concurrent();
    repeat (4) @(posedge ACLK);

    $display("Checks: %0d, value errors: %0d, assertion errors: %0d",
             checks, errors, uut.u_checker.fail_cnt);
    if (errors == 0 && uut.u_checker.fail_cnt == 0)
    begin
      $display("ALL TESTS PASSED");
    end
    else
    begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- verilog/axi_mem_bridge.sv
/* AXI4 slave onto one single-port SRAM. One read and one write transaction
   in flight at a time, responses always OKAY, no RRESP or BRESP ports */
`timescale 1ns/10ps

module axi_mem_bridge
(
  input  logic                               ACLK,
  input  logic                               ARESETn,

  // Write address, data and response
  input  axi_mem_pkg::axi_addr_t             aw_i,
  input  logic                               aw_valid_i,
  output logic                               aw_ready_o,
  input  axi_mem_pkg::axi_w_t                w_i,
  input  logic                               w_valid_i,
  output logic                               w_ready_o,
  output logic [axi_mem_pkg::ID_W-1:0]       b_id_o,
  output logic                               b_valid_o,
  input  logic                               b_ready_i,

  // Read address and data
  input  axi_mem_pkg::axi_addr_t             ar_i,
  input  logic                               ar_valid_i,
  output logic                               ar_ready_o,
  output axi_mem_pkg::axi_r_t                r_o,
  output logic                               r_valid_o,
  input  logic                               r_ready_i,

  // SRAM pins, CEN and WEN active low
  output logic                               mem_cen_o,
  output logic                               mem_wen_o,
  output logic [axi_mem_pkg::MEM_ADDR_W-1:0] mem_addr_o,
  output logic [axi_mem_pkg::DATA_W-1:0]     mem_d_o,
  output logic [axi_mem_pkg::STRB_W-1:0]     mem_be_o,
  input  logic [axi_mem_pkg::DATA_W-1:0]     mem_q_i
);

  logic                  rd_req;
  logic                  rd_gnt;
  axi_mem_pkg::mem_req_t rd_mem;
  logic                  wr_req;
  logic                  wr_gnt;
  axi_mem_pkg::mem_req_t wr_mem;

  axi_read_engine u_read
  (
    .ACLK       ( ACLK       ),
    .ARESETn    ( ARESETn    ),
    .ar_i       ( ar_i       ),
    .ar_valid_i ( ar_valid_i ),
    .ar_ready_o ( ar_ready_o ),
    .r_o        ( r_o        ),
    .r_valid_o  ( r_valid_o  ),
    .r_ready_i  ( r_ready_i  ),
    .rd_req_o   ( rd_req     ),
    .rd_mem_o   ( rd_mem     ),
    .rd_gnt_i   ( rd_gnt     ),
    .mem_q_i    ( mem_q_i    )
  );

  axi_write_engine u_write
  (
    .ACLK       ( ACLK       ),
    .ARESETn    ( ARESETn    ),
    .aw_i       ( aw_i       ),
    .aw_valid_i ( aw_valid_i ),
    .aw_ready_o ( aw_ready_o ),
    .w_i        ( w_i        ),
    .w_valid_i  ( w_valid_i  ),
    .w_ready_o  ( w_ready_o  ),
    .b_id_o     ( b_id_o     ),
    .b_valid_o  ( b_valid_o  ),
    .b_ready_i  ( b_ready_i  ),
    .wr_req_o   ( wr_req     ),
    .wr_mem_o   ( wr_mem     ),
    .wr_gnt_i   ( wr_gnt     )
  );

  mem_port_arbiter u_arb
  (
    .ACLK       ( ACLK       ),
    .ARESETn    ( ARESETn    ),
    .rd_req_i   ( rd_req     ),
    .rd_mem_i   ( rd_mem     ),
    .wr_req_i   ( wr_req     ),
    .wr_mem_i   ( wr_mem     ),
    .rd_gnt_o   ( rd_gnt     ),
    .wr_gnt_o   ( wr_gnt     ),
    .mem_cen_o  ( mem_cen_o  ),
    .mem_wen_o  ( mem_wen_o  ),
    .mem_addr_o ( mem_addr_o ),
    .mem_d_o    ( mem_d_o    ),
    .mem_be_o   ( mem_be_o   )
  );

endmodule

//--- verilog/mem_port_arbiter.sv
/* Single-cycle grant, returned in the same cycle as the request. SRAM pins
   are combinational from the winner; read data appears one cycle later */
`timescale 1ns/10ps

module mem_port_arbiter
(
  input  logic                               ACLK,
  input  logic                               ARESETn,
  input  logic                               rd_req_i,
  input  axi_mem_pkg::mem_req_t              rd_mem_i,
  input  logic                               wr_req_i,
  input  axi_mem_pkg::mem_req_t              wr_mem_i,
  output logic                               rd_gnt_o,
  output logic                               wr_gnt_o,
  output logic                               mem_cen_o,
  output logic                               mem_wen_o,
  output logic [axi_mem_pkg::MEM_ADDR_W-1:0] mem_addr_o,
  output logic [axi_mem_pkg::DATA_W-1:0]     mem_d_o,
  output logic [axi_mem_pkg::STRB_W-1:0]     mem_be_o
);

  logic                  wr_first_q;  // High favours the write engine
  logic                  contested;
  logic                  any_gnt;
  axi_mem_pkg::mem_req_t sel;

  // ----------------------------------------------------------
  // Round-robin grant
  // ----------------------------------------------------------
  assign contested = rd_req_i & wr_req_i;

  assign rd_gnt_o = rd_req_i & ~(wr_req_i & wr_first_q);
  assign wr_gnt_o = wr_req_i & ~(rd_req_i & ~wr_first_q);

  // Loser of a contested cycle wins the next one
  always_ff @(posedge ACLK, negedge ARESETn)
  begin
    if (!ARESETn)
      wr_first_q <= 1'b0;
    else if (contested)
      wr_first_q <= rd_gnt_o;
  end

  // ----------------------------------------------------------
  // SRAM pin drive
  // ----------------------------------------------------------
  assign any_gnt = rd_gnt_o | wr_gnt_o;
  assign sel     = wr_gnt_o ? wr_mem_i : rd_mem_i;

  assign mem_cen_o  = ~any_gnt;
  assign mem_wen_o  = ~(any_gnt & (sel.op == axi_mem_pkg::MEM_WRITE));
  assign mem_addr_o = sel.addr;
  assign mem_d_o    = sel.wdata;
  assign mem_be_o   = sel.be;   // Byte lanes of the write

endmodule
